//--- vlog.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_alu.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

//--- tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Architectural registers as the program sees them
xlen_t arch_regs [32];

function automatic void model_reset();
  foreach (arch_regs[k]) begin
    arch_regs[k] = '0;
  end
endfunction

// Integer op chosen by funct3
// alt picks sub over add and sra over srl
function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
  xlen_t y;
  case (f3)
    3'd0: y = alt ? a - b : a + b;
    3'd1: y = a << b[4:0];
    3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: y = (a < b) ? 32'd1 : 32'd0;
    3'd4: y = a ^ b;
    3'd5: y = alt ? xlen_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
    3'd6: y = a | b;
    default: y = a & b;
  endcase
  return y;
endfunction

// Retire one word in program order, return what the core should emit
function automatic res_out_s model_step(input xlen_t word, input xlen_t pc);
  res_out_s r;
  logic [2:0] f3;
  logic [6:0] f7;
  xlen_t a;
  xlen_t b;
  xlen_t y;
  logic legal;
  f3 = word[14:12];
  f7 = word[31:25];
  a = arch_regs[word[19:15]];
  b = arch_regs[word[24:20]];
  y = '0;
  legal = 1'b1;
  if (word[6:0] == OPC_OP) begin
    // Alternate funct7 only for sub and sra
    legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    y = alu_model(f3, f7[5], a, b);
  end else if (word[6:0] == OPC_OP_IMM) begin
    b = {{20{word[31]}}, word[31:20]};
    // Shifts take shamt, upper imm bits constrained
    if (f3 == 3'd1 || f3 == 3'd5) begin
      legal = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
      b = {27'b0, word[24:20]};
    end
    y = alu_model(f3, (f3 == 3'd5) && word[30], a, b);
  end else if (word[6:0] == OPC_LUI) begin
    y = {word[31:12], 12'h000};
  end else begin
    legal = 1'b0;
  end
  // x0 stays zero, illegal words leave state alone
  if (legal && word[11:7] != 5'd0) begin
    arch_regs[word[11:7]] = y;
  end
  r.rd = word[11:7];
  r.value = y;
  r.illegal = !legal;
  r.pc = pc;
  return r;
endfunction

`endif

//--- tb_rv_core.sv
`default_nettype none
`timescale 1ns/10ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int N_DIRECTED = 200;
  localparam int N_TOTAL = 2000;
  localparam int TIMEOUT_CYCLES = N_TOTAL * 20;

  logic bus;
  logic rst;
  logic in_valid;
  rv_instr_u in_instr;
  xlen_t in_pc;
  logic in_ready;
  logic res_ready;
  logic res_valid;
  res_out_s res;

  // Scoreboard state
  res_out_s exp_q [$];
  int acc_q [$];
  res_out_s exp_res;
  res_out_s held_res;
  logic [31:0] lfsr_state;
  logic fire_in;
  logic fire_out;
  logic stalled;
  xlen_t next_pc;
  int n_acc;
  int n_out;
  int cyc;
  int acc_cyc;
  int timeout_cnt;

  `include "tb_rv_model.svh"

  rv_core_top #(.REG_COUNT(32)) dut (
    .bus(bus), .rst(rst),
    .in_valid(in_valid), .in_instr(in_instr), .in_pc(in_pc), .in_ready(in_ready),
    .res_ready(res_ready), .res_valid(res_valid), .res(res)
  );

  // 8 ns clock
  initial bus = 1'b0;
  always #4 bus = ~bus;

  //////////////////////////////////////////////////
  // Failure handling
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("Output did not match the reference model");
    end
  endtask

  // Run limit counted from time zero
  always @(posedge bus) begin
    timeout_cnt++;
    if (timeout_cnt > TIMEOUT_CYCLES) begin
      abort_run("Timeout, the pipeline stopped retiring results");
    end
  end

  //////////////////////////////////////////////////
  // Random stimulus
  //////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Mostly x0..x3 so hazards are frequent
  function automatic reg_idx_t pick_reg();
    if (rand_bits(3) < 6) begin
      return reg_idx_t'(rand_bits(2));
    end
    return reg_idx_t'(rand_bits(5));
  endfunction

  function automatic xlen_t gen_word();
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic [2:0] f3;
    logic [3:0] kind;
    logic [6:0] f7;
    logic [11:0] imm;
    xlen_t w;
    rd = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3 = 3'(rand_bits(3));
    kind = 4'(rand_bits(4));
    f7 = 7'h00;
    if (rand_bits(5) == 0) begin
      // Roughly 3 percent bad words
      case (rand_bits(2))
        0: w = {25'(rand_bits(25)), 7'b0000011};
        1: w = {7'h01, rs2, rs1, f3, rd, OPC_OP};
        2: w = {7'h20, rs2, rs1, 3'b001, rd, OPC_OP_IMM};
        default: w = {7'h20, rs2, rs1, 3'b110, rd, OPC_OP};
      endcase
    end else if (kind < 7) begin
      if ((f3 == 3'd0 || f3 == 3'd5) && next_bit()) begin
        f7 = 7'h20;
      end
      w = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 14) begin
      imm = 12'(rand_bits(12));
      if (f3 == 3'd1) begin
        imm = {7'h00, rs2};
      end else if (f3 == 3'd5) begin
        imm = {next_bit() ? 7'h20 : 7'h00, rs2};
      end
      w = {imm, rs1, f3, rd, OPC_OP_IMM};
    end else begin
      w = {20'(rand_bits(20)), rd, OPC_LUI};
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Per-cycle drive, sample and scoreboard
  //////////////////////////////////////////////////

  // Held word stays until taken
  task automatic drive_inputs();
    if (!in_valid || fire_in) begin
      if (n_acc < N_TOTAL && (n_acc < N_DIRECTED || rand_bits(2) != 0)) begin
        in_valid = 1'b1;
        in_instr = gen_word();
        in_pc = next_pc;
        next_pc = next_pc + 4;
      end else begin
        in_valid = 1'b0;
      end
    end
    // Directed phase keeps the output always ready
    res_ready = (n_out < N_DIRECTED) ? 1'b1 : (rand_bits(2) != 0);
  endtask

  // Settled values hold until the next rising edge
  task automatic sample_outputs();
    if (cyc == 0) begin
      check_value("res_valid after reset", res_valid, 0);
      check_value("in_ready after reset", in_ready, 1);
    end
    if (stalled) begin
      check_value("res_valid while stalled", res_valid, 1);
      check_value("res.rd while stalled", res.rd, held_res.rd);
      check_value("res.value while stalled", res.value, held_res.value);
      check_value("res.illegal while stalled", res.illegal, held_res.illegal);
      check_value("res.pc while stalled", res.pc, held_res.pc);
    end
    fire_in = in_valid && in_ready;
    fire_out = res_valid && res_ready;
    stalled = res_valid && !res_ready;
    held_res = res;
  endtask

  task automatic score_edge();
    if (fire_out) begin
      if (exp_q.size() == 0) begin
        abort_run("A result came out with no instruction in flight");
      end
      exp_res = exp_q.pop_front();
      acc_cyc = acc_q.pop_front();
      check_value("res.pc", held_res.pc, exp_res.pc);
      check_value("res.rd", held_res.rd, exp_res.rd);
      check_value("res.illegal", held_res.illegal, exp_res.illegal);
      if (!exp_res.illegal) begin
        check_value("res.value", held_res.value, exp_res.value);
      end
      if (n_out < N_DIRECTED) begin
        check_value("latency", 32'(cyc - acc_cyc), 3);
      end
      n_out++;
    end
    if (fire_in) begin
      exp_q.push_back(model_step(in_instr, in_pc));
      acc_q.push_back(cyc);
      n_acc++;
    end
  endtask

  initial begin
    lfsr_state = 32'hc34b6e23;
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    res_ready = 1'b0;
    fire_in = 1'b0;
    stalled = 1'b0;
    next_pc = 32'h0000_1000;
    model_reset();
    repeat (10) @(negedge bus);
    rst = 1'b0;
    while (n_out < N_TOTAL) begin
      drive_inputs();
      #1;
      sample_outputs();
      @(posedge bus);
      cyc++;
      score_edge();
      @(negedge bus);
    end
    // Nothing more may come out during the drain
    in_valid = 1'b0;
    res_ready = 1'b1;
    repeat (5) begin
      @(negedge bus);
      check_value("res_valid after drain", res_valid, 0);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core_top.sv
`default_nettype none
`timescale 1ns/10ps

module rv_core_top #(
  parameter int REG_COUNT = 32
) (
  input  wire               bus,
  input  wire               rst,
  input  wire               in_valid,
  input  rv_pkg::rv_instr_u in_instr,
  input  rv_pkg::xlen_t     in_pc,
  output logic              in_ready,
  input  wire               res_ready,
  output logic              res_valid,
  output rv_pkg::res_out_s  res
);
  import rv_pkg::*;

  logic     advance;
  reg_idx_t rd_idx1;
  reg_idx_t rd_idx2;
  xlen_t    rd_data1;
  xlen_t    rd_data2;
  id_ex_s   id_ex;
  ex_res_s  ex_res;
  ex_res_s  fwd_res;
  logic     wr_en;
  reg_idx_t wr_idx;
  xlen_t    wr_data;

  // Whole pipe moves unless a result is stuck at the output
  assign advance  = !res_valid || res_ready;
  assign in_ready = advance;

  //////////////////////////////////////////////////
  // Stages and register file
  //////////////////////////////////////////////////

  rv_regfile #(.REG_COUNT(REG_COUNT)) u_regfile (
    .bus(bus), .rst(rst),
    .rd_idx1(rd_idx1), .rd_idx2(rd_idx2),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .rd_data1(rd_data1), .rd_data2(rd_data2)
  );

  rv_decode #(.REG_COUNT(REG_COUNT)) u_decode (
    .bus(bus), .rst(rst), .advance(advance),
    .in_valid(in_valid), .in_instr(in_instr), .in_pc(in_pc),
    .rd_data1(rd_data1), .rd_data2(rd_data2),
    .rd_idx1(rd_idx1), .rd_idx2(rd_idx2),
    .id_ex(id_ex)
  );

  rv_execute u_execute (
    .bus(bus), .rst(rst), .advance(advance),
    .id_ex(id_ex), .fwd_res(fwd_res),
    .ex_res(ex_res)
  );

  rv_result u_result (
    .bus(bus), .rst(rst), .advance(advance),
    .ex_res(ex_res), .res_ready(res_ready),
    .res_valid(res_valid), .res(res), .fwd_res(fwd_res),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
  );

endmodule

`default_nettype wire

//--- rv_result.sv
`default_nettype none
`timescale 1ns/10ps

module rv_result (
  input  wire              bus,
  input  wire              rst,
  input  wire              advance,
  input  rv_pkg::ex_res_s  ex_res,
  input  wire              res_ready,
  output logic             res_valid,
  output rv_pkg::res_out_s res,
  output rv_pkg::ex_res_s  fwd_res,
  output logic             wr_en,
  output rv_pkg::reg_idx_t wr_idx,
  output rv_pkg::xlen_t    wr_data
);
  import rv_pkg::*;

  // Oldest in-flight result
  ex_res_s res_q;

  always_ff @(posedge bus) begin
    if (rst) begin
      res_q.valid    <= 1'b0;
      res_q.illegal  <= 1'b0;
      res_q.regwrite <= 1'b0;
    end else if (advance) begin
      res_q <= ex_res;
    end
  end

  // Output stream
  assign res_valid   = res_q.valid;
  assign res.rd      = res_q.rd;
  assign res.value   = res_q.value;
  assign res.illegal = res_q.illegal;
  assign res.pc      = res_q.pc;

  // Still a forwarding source until it retires
  assign fwd_res = res_q;

  // Write-back only on the transfer edge
  assign wr_en   = res_q.valid && res_q.regwrite && res_ready;
  assign wr_idx  = res_q.rd;
  assign wr_data = res_q.value;

  // Stalled result must hold, which relies on the top level freezing advance
  a_res_stable: assert property (@(posedge bus) disable iff (rst)
    (res_valid && !res_ready) |=> (res_valid && $stable(res)));

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none
`timescale 1ns/10ps

module rv_execute (
  input  wire             bus,
  input  wire             rst,
  input  wire             advance,
  input  rv_pkg::id_ex_s  id_ex,
  input  rv_pkg::ex_res_s fwd_res,
  output rv_pkg::ex_res_s ex_res
);
  import rv_pkg::*;

  xlen_t op_a;
  xlen_t rs2_fwd;
  xlen_t op_b;
  xlen_t alu_y;

  // Pick the newest in-flight value of one source register
  // ex_res holds the younger of the two candidates
  function automatic xlen_t fwd_operand(
    input reg_idx_t idx,
    input xlen_t    dec_val,
    input ex_res_s  near,
    input ex_res_s  far
  );
    xlen_t val;
    if (near.valid && near.regwrite && near.rd == idx) begin
      val = near.value;
    end else if (far.valid && far.regwrite && far.rd == idx) begin
      val = far.value;
    end else begin
      val = dec_val;
    end
    return val;
  endfunction

  //////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////

  // regwrite is never set for x0, so x0 reads stay zero
  assign op_a    = fwd_operand(id_ex.rs1, id_ex.rs1_val, ex_res, fwd_res);
  assign rs2_fwd = fwd_operand(id_ex.rs2, id_ex.rs2_val, ex_res, fwd_res);

  // Immediate forms replace the second source
  assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  rv_alu u_alu (
    .op (id_ex.op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

  //////////////////////////////////////////////////
  // Execute/result register
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      ex_res.valid    <= 1'b0;
      ex_res.illegal  <= 1'b0;
      ex_res.regwrite <= 1'b0;
    end else if (advance) begin
      // Control fields
      ex_res.valid    <= id_ex.valid;
      ex_res.illegal  <= id_ex.valid && id_ex.illegal;
      ex_res.regwrite <= id_ex.valid && id_ex.regwrite;
      // Payload
      ex_res.rd       <= id_ex.rd;
      ex_res.value    <= alu_y;
      ex_res.pc       <= id_ex.pc;
    end
  end

endmodule

`default_nettype wire

//--- rv_alu.sv
`default_nettype none
`timescale 1ns/10ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::xlen_t   a,
  input  rv_pkg::xlen_t   b,
  output rv_pkg::xlen_t   y
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shift amount from the low bits of b only
  assign shamt = b[4:0];

  // Comparisons for slt and sltu
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      // Arithmetic shift keeps the sign
      ALU_SRA: begin
        y = xlen_t'($signed(a) >>> shamt);
      end
      ALU_SLT: begin
        y = {31'b0, lt_signed};
      end
      ALU_SLTU: begin
        y = {31'b0, lt_unsigned};
      end
      // lui, immediate already placed by decode
      ALU_PASSB: begin
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none
`timescale 1ns/10ps

module rv_decode #(
  parameter int REG_COUNT = 32
) (
  input  wire               bus,
  input  wire               rst,
  input  wire               advance,
  input  wire               in_valid,
  input  rv_pkg::rv_instr_u in_instr,
  input  rv_pkg::xlen_t     in_pc,
  input  rv_pkg::xlen_t     rd_data1,
  input  rv_pkg::xlen_t     rd_data2,
  output rv_pkg::reg_idx_t  rd_idx1,
  output rv_pkg::reg_idx_t  rd_idx2,
  output rv_pkg::id_ex_s    id_ex
);
  import rv_pkg::*;

  alu_op_e dec_op;
  xlen_t   dec_imm;
  logic    use_imm;
  logic    uses_rs1;
  logic    uses_rs2;
  logic    known;
  logic    idx_ok;
  logic    illegal;
  id_ex_s  id_next;

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////

  always_comb begin
    dec_op   = ALU_ADD;
    dec_imm  = '0;
    use_imm  = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    known    = 1'b0;
    case (in_instr.r.opcode)
      OPC_OP: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        // Only sub and sra carry the alternate funct7
        known = (in_instr.r.funct7 == 7'h00) ||
                (in_instr.r.funct7 == 7'h20 &&
                 (in_instr.r.funct3 == 3'b000 || in_instr.r.funct3 == 3'b101));
        case (in_instr.r.funct3)
          3'b000:  dec_op = in_instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001:  dec_op = ALU_SLL;
          3'b010:  dec_op = ALU_SLT;
          3'b011:  dec_op = ALU_SLTU;
          3'b100:  dec_op = ALU_XOR;
          3'b101:  dec_op = in_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  dec_op = ALU_OR;
          default: dec_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        uses_rs1 = 1'b1;
        use_imm  = 1'b1;
        known    = 1'b1;
        // Sign-extended imm12 unless a shift overrides it
        dec_imm  = {{20{in_instr.i.imm12[11]}}, in_instr.i.imm12};
        case (in_instr.i.funct3)
          3'b000: dec_op = ALU_ADD;
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b110: dec_op = ALU_OR;
          3'b111: dec_op = ALU_AND;
          3'b001: begin
            dec_op  = ALU_SLL;
            dec_imm = {27'b0, in_instr.i.imm12[4:0]};
            known   = (in_instr.i.imm12[11:5] == 7'h00);
          end
          default: begin
            // srli or srai, told apart by imm bit 10
            dec_op  = in_instr.i.imm12[10] ? ALU_SRA : ALU_SRL;
            dec_imm = {27'b0, in_instr.i.imm12[4:0]};
            known   = (in_instr.i.imm12[11:5] == 7'h00) ||
                      (in_instr.i.imm12[11:5] == 7'h20);
          end
        endcase
      end
      OPC_LUI: begin
        use_imm = 1'b1;
        known   = 1'b1;
        dec_op  = ALU_PASSB;
        // Upper 20 bits rebuilt from the I-type fields
        dec_imm = {in_instr.i.imm12, in_instr.i.rs1, in_instr.i.funct3, 12'h000};
      end
      default: ;
    endcase
  end

  // Indices beyond a reduced file make the word illegal
  assign idx_ok = (in_instr.r.rd < REG_COUNT) &&
                  (!uses_rs1 || in_instr.r.rs1 < REG_COUNT) &&
                  (!uses_rs2 || in_instr.r.rs2 < REG_COUNT);
  assign illegal = !(known && idx_ok);

  // Unused sources read x0, which never forwards
  assign rd_idx1 = (uses_rs1 && !illegal) ? in_instr.r.rs1 : '0;
  assign rd_idx2 = (uses_rs2 && !illegal) ? in_instr.r.rs2 : '0;

  //////////////////////////////////////////////////
  // Decode/execute register
  //////////////////////////////////////////////////

  always_comb begin
    id_next.valid    = in_valid;
    id_next.illegal  = in_valid && illegal;
    id_next.op       = dec_op;
    id_next.use_imm  = use_imm;
    id_next.regwrite = in_valid && !illegal && (in_instr.r.rd != '0);
    id_next.rd       = in_instr.r.rd;
    id_next.rs1      = rd_idx1;
    id_next.rs2      = rd_idx2;
    id_next.rs1_val  = rd_data1;
    id_next.rs2_val  = rd_data2;
    id_next.imm      = dec_imm;
    id_next.pc       = in_pc;
  end

  // Bubble when nothing is offered
  always_ff @(posedge bus) begin
    if (rst) begin
      id_ex.valid    <= 1'b0;
      id_ex.illegal  <= 1'b0;
      id_ex.regwrite <= 1'b0;
    end else if (advance) begin
      id_ex <= id_next;
    end
  end

  // Accepted legal OP word turns into sub or sra exactly when funct7 bit 5 is set
  a_f7_sub_sra: assert property (@(posedge bus) disable iff (rst)
    (advance && in_valid && in_instr.r.opcode == OPC_OP && !illegal)
    |=> ((id_ex.op inside {ALU_SUB, ALU_SRA}) == $past(in_instr.r.funct7[5])));

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module rv_regfile #(
  parameter int REG_COUNT = 32
) (
  input  wire              bus,
  input  wire              rst,
  input  rv_pkg::reg_idx_t rd_idx1,
  input  rv_pkg::reg_idx_t rd_idx2,
  input  wire              wr_en,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::xlen_t    wr_data,
  output rv_pkg::xlen_t    rd_data1,
  output rv_pkg::xlen_t    rd_data2
);
  import rv_pkg::*;

  // Architectural registers
  xlen_t regs [REG_COUNT];

  // Whole file cleared on reset
  // x0 is never written
  always_ff @(posedge bus) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Read ports
  // Same-cycle write shows through to a reader in decode
  always_comb begin
    if (rd_idx1 == '0) begin
      rd_data1 = '0;
    end else if (wr_en && wr_idx == rd_idx1) begin
      rd_data1 = wr_data;
    end else begin
      rd_data1 = regs[rd_idx1];
    end
  end

  always_comb begin
    if (rd_idx2 == '0) begin
      rd_data2 = '0;
    end else if (wr_en && wr_idx == rd_idx2) begin
      rd_data2 = wr_data;
    end else begin
      rd_data2 = regs[rd_idx2];
    end
  end

  // Decode and result stage only ever present indices the file holds
  a_idx_range: assert property (@(posedge bus) disable iff (rst)
    (rd_idx1 < REG_COUNT) && (rd_idx2 < REG_COUNT) && (!wr_en || wr_idx < REG_COUNT));

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Basic word and index types
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  // ALU operation codes
  // Pass-b only serves lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASSB
  } alu_op_e;

  //////////////////////////////////////////////////
  // Instruction word, two views of the same bits
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } rv_rtype_s;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } rv_itype_s;

  typedef union packed {
    rv_rtype_s r;
    rv_itype_s i;
  } rv_instr_u;

  // Major opcodes kept in this slice
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  //////////////////////////////////////////////////
  // Pipeline records
  //////////////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic     valid;
    logic     illegal;
    alu_op_e  op;
    logic     use_imm;
    logic     regwrite;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    imm;
    xlen_t    pc;
  } id_ex_s;

  // Execute to result
  typedef struct packed {
    logic     valid;
    logic     illegal;
    logic     regwrite;
    reg_idx_t rd;
    xlen_t    value;
    xlen_t    pc;
  } ex_res_s;

  // Retired result on the output stream
  typedef struct packed {
    reg_idx_t rd;
    xlen_t    value;
    logic     illegal;
    xlen_t    pc;
  } res_out_s;

endpackage

`default_nettype wire
